// ==== flist.f ====
+incdir+include
src/prbs_pkg.sv
src/prbs_seed_gen.sv
src/prbs_lfsr_bank.sv
src/prbs_checker_core.sv
src/prbs_checker.sv
src/prbs_bist_top.sv
verification/tb_prbs_bist.sv

// ==== include/prbs_defines.svh ====
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// PRBS7 polynomial x^7 + x^6 + 1
`define PRBS_ORDER 7

// feedback taps as state bit indices
`define PRBS_TAP_HI 6
`define PRBS_TAP_LO 5

// lanes per parallel word
`define PRBS_LANES 16
`define PRBS_SHIFT_W 4
`define PRBS_MATCH_W 5

`define PRBS_CNT_W 64

// consecutive bad words before the window slips
`define PRBS_ALIGN_ERRS 4

// any nonzero state works as the base
`define PRBS_BASE_SEED {`PRBS_ORDER{1'b1}}

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the PRBS BIST testbench
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
    --top-module tb_prbs_bist -f flist.f > build.log 2>&1 \
    && ./obj_dir/Vtb_prbs_bist > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// ==== src/prbs_bist_top.sv ====
`timescale 1ns/10ps
`include "prbs_defines.svh"

module prbs_bist_top (
    input  logic                     clk,
    input  logic                     rst,
    input  prbs_pkg::checker_mode_t  checker_mode,
    input  prbs_pkg::lane_word_t     rx_bits,
    output prbs_pkg::lane_word_t     tx_bits,
    output prbs_pkg::bit_count_t     correct_bits,
    output prbs_pkg::bit_count_t     total_bits,
    output logic [`PRBS_SHIFT_W-1:0] rx_shift
);

    // shared by transmit and receive so both walk the same sequence
    prbs_pkg::lane_states_t seeds;

    prbs_seed_gen seed_gen_i (
        .base  (`PRBS_BASE_SEED),
        .seeds (seeds)
    );

    // transmit pattern runs freely once rst drops
    prbs_lfsr_bank tx_bank_i (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .seeds (seeds),
        .bits  (tx_bits)
    );

    prbs_checker checker_i (
        .clk          (clk),
        .rst          (rst),
        .seeds        (seeds),
        .rx_bits      (rx_bits),
        .checker_mode (checker_mode),
        .correct_bits (correct_bits),
        .total_bits   (total_bits),
        .rx_shift     (rx_shift)
    );

endmodule

// ==== src/prbs_checker.sv ====
`timescale 1ns/10ps
`include "prbs_defines.svh"

module prbs_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  prbs_pkg::lane_states_t    seeds,
    input  prbs_pkg::lane_word_t      rx_bits,
    input  prbs_pkg::checker_mode_t   checker_mode,
    output prbs_pkg::bit_count_t      correct_bits,
    output prbs_pkg::bit_count_t      total_bits,
    output logic [`PRBS_SHIFT_W-1:0]  rx_shift
);

    // err_count value at which the next bad word triggers a slip
    localparam logic [1:0] err_last = 2'(`PRBS_ALIGN_ERRS - 1);

    prbs_pkg::checker_mode_t mode;

    logic lfsr_rst;
    logic lfsr_en;
    logic match;
    logic [`PRBS_MATCH_W-1:0] match_count;

    // consecutive mismatches seen while aligning
    logic [1:0] err_count;

    prbs_checker_core core_i (
        .clk         (clk),
        .rst         (lfsr_rst),
        .en          (lfsr_en),
        .seeds       (seeds),
        .rx_bits     (rx_bits),
        .rx_shift    (rx_shift),
        .match       (match),
        .match_count (match_count)
    );

    // top reset looks like reset mode from here on
    assign mode = rst ? prbs_pkg::mode_reset : checker_mode;

    always_ff @(posedge clk) begin
        case (mode)
            prbs_pkg::mode_reset: begin
                lfsr_rst     <= 1'b1;
                lfsr_en      <= 1'b0;
                rx_shift     <= '1;
                err_count    <= '0;
                correct_bits <= '0;
                total_bits   <= '0;
            end
            prbs_pkg::mode_align: begin
                lfsr_rst     <= 1'b0;
                correct_bits <= '0;
                total_bits   <= '0;
                if (match) begin
                    lfsr_en   <= 1'b1;
                    err_count <= '0;
                end else if (err_count == err_last) begin
                    err_count <= '0;
                    if (rx_shift == '0) begin
                        // wrap the window and let the reference fall back a word
                        lfsr_en  <= 1'b0;
                        rx_shift <= '1;
                    end else begin
                        lfsr_en  <= 1'b1;
                        rx_shift <= rx_shift - 1'b1;
                    end
                end else begin
                    lfsr_en   <= 1'b1;
                    err_count <= err_count + 1'b1;
                end
            end
            prbs_pkg::mode_test: begin
                lfsr_rst     <= 1'b0;
                lfsr_en      <= 1'b1;
                err_count    <= '0;
                correct_bits <= correct_bits + prbs_pkg::bit_count_t'(match_count);
                total_bits   <= total_bits + prbs_pkg::bit_count_t'(`PRBS_LANES);
            end
            default: begin
                // freeze keeps counters, shift and core control as they are
            end
        endcase
    end

endmodule

// ==== src/prbs_checker_core.sv ====
`timescale 1ns/10ps
`include "prbs_defines.svh"

module prbs_checker_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en,
    input  prbs_pkg::lane_states_t   seeds,
    input  prbs_pkg::lane_word_t     rx_bits,
    input  logic [`PRBS_SHIFT_W-1:0] rx_shift,
    output logic                     match,
    output logic [`PRBS_MATCH_W-1:0] match_count
);

    // expected pattern
    prbs_pkg::lane_word_t ref_bits;

    prbs_pkg::lane_word_t rx_prev;
    logic [2*`PRBS_LANES-1:0] rx_joined;
    prbs_pkg::lane_word_t window;

    prbs_pkg::lane_word_t agree;
    logic [`PRBS_MATCH_W-1:0] agree_count;

    prbs_lfsr_bank ref_bank_i (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .seeds (seeds),
        .bits  (ref_bits)
    );

    // last received word, needed for windows that straddle two words
    always_ff @(posedge clk) begin
        rx_prev <= rx_bits;
    end

    // older word in the low half so bit order follows the serial stream
    assign rx_joined = {rx_bits, rx_prev};

    // rx_shift picks where in the two words the window starts
    assign window = rx_joined[rx_shift +: `PRBS_LANES];

    assign agree = ~(window ^ ref_bits);

    // number of lanes that agree with the reference
    always_comb begin
        agree_count = '0;
        for (int lane = 0; lane < `PRBS_LANES; lane++) begin
            agree_count = agree_count + {{(`PRBS_MATCH_W-1){1'b0}}, agree[lane]};
        end
    end

    // results come one clock after the word they describe
    always_ff @(posedge clk) begin
        if (rst) begin
            match       <= 1'b0;
            match_count <= '0;
        end else begin
            match       <= &agree;
            match_count <= agree_count;
        end
    end

endmodule

// ==== src/prbs_lfsr_bank.sv ====
`timescale 1ns/10ps
`include "prbs_defines.svh"

module prbs_lfsr_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  prbs_pkg::lane_states_t seeds,
    output prbs_pkg::lane_word_t   bits
);

    prbs_pkg::lane_states_t state;
    prbs_pkg::lane_states_t state_next;
    prbs_pkg::lane_word_t   top_bits;

    // every lane jumps a whole word ahead
    // the inner loop unrolls into a 16 step XOR network per lane
    always_comb begin
        state_next = state;
        for (int lane = 0; lane < `PRBS_LANES; lane++) begin
            for (int n = 0; n < `PRBS_LANES; n++) begin
                state_next[lane] = prbs_pkg::lfsr_step(state_next[lane]);
            end
        end
    end

    // output bit of each lane is its current top bit
    always_comb begin
        for (int lane = 0; lane < `PRBS_LANES; lane++) begin
            top_bits[lane] = state[lane][`PRBS_ORDER-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seeds;
        end else if (en) begin
            state <= state_next;
        end
    end

    // word register follows the lane states
    // holding en repeats one word, which slips this stream by a word
    always_ff @(posedge clk) begin
        bits <= top_bits;
    end

endmodule

// ==== src/prbs_pkg.sv ====
`include "prbs_defines.svh"

package prbs_pkg;

    // encodings match the external mode pins
    typedef enum logic [1:0] {
        mode_reset  = 2'b00,
        mode_align  = 2'b01,
        mode_test   = 2'b10,
        mode_freeze = 2'b11
    } checker_mode_t;

    // one bit per lane, lane 0 is the earliest serial bit
    typedef logic [`PRBS_LANES-1:0] lane_word_t;

    typedef logic [`PRBS_ORDER-1:0] lfsr_state_t;

    typedef lfsr_state_t [`PRBS_LANES-1:0] lane_states_t;

    typedef logic [`PRBS_CNT_W-1:0] bit_count_t;

    // one serial step, the top bit is the bit shifted out
    function automatic lfsr_state_t lfsr_step(lfsr_state_t s);
        return {s[`PRBS_ORDER-2:0], s[`PRBS_TAP_HI] ^ s[`PRBS_TAP_LO]};
    endfunction

endpackage

// ==== src/prbs_seed_gen.sv ====
`timescale 1ns/10ps
`include "prbs_defines.svh"

// Lane i of a parallel word carries serial bit i of that word. Each lane
// runs its own copy of the LFSR, advanced by a full word per clock, so the
// lane seeds must sit i steps apart along the same sequence.
module prbs_seed_gen (
    input  prbs_pkg::lfsr_state_t  base,
    output prbs_pkg::lane_states_t seeds
);

    // chain[i] is the base state stepped i times
    prbs_pkg::lane_states_t chain;

    assign chain[0] = base;

    generate
        for (genvar lane = 1; lane < `PRBS_LANES; lane++) begin : g_chain
            assign chain[lane] = prbs_pkg::lfsr_step(chain[lane-1]);
        end
    endgenerate

    // lane 0 starts right at the base state
    assign seeds = chain;

endmodule

// ==== verification/tb_prbs_bist.sv ====
`timescale 1ns/10ps
`include "prbs_defines.svh"

module tb_prbs_bist;

    // one window search, 16 shifts over 2 words at 5 cycles each
    localparam int align_cycles  = 16 * 2 * 5;
    localparam int stable_cycles = 20;
    localparam int clean_cycles  = 100;
    localparam int error_cycles  = 200;
    localparam int drain_cycles  = 8;
    localparam int freeze_cycles = 30;
    localparam int phase_cycles  = 2 * (4 + stable_cycles + clean_cycles)
                                   + error_cycles + drain_cycles + freeze_cycles + 4;
    localparam int cycle_limit   = 2 * align_cycles + phase_cycles + 2000;

    logic                     clk = 1'b0;
    logic                     rst;
    prbs_pkg::checker_mode_t  checker_mode;
    prbs_pkg::lane_word_t     rx_bits = '0;
    prbs_pkg::lane_word_t     tx_bits;
    prbs_pkg::bit_count_t     correct_bits;
    prbs_pkg::bit_count_t     total_bits;
    logic [`PRBS_SHIFT_W-1:0] rx_shift;

    integer seed;
    int     delay;
    logic   inject_on;
    logic   clean_check;
    int     flips_injected = 0;
    int     value_errors = 0;
    int     cycle_count = 0;

    // last three transmitted words, oldest in the low bits
    logic [3*`PRBS_LANES-1:0] tx_hist = '0;

    // next seven bits of the serial stream, earliest in bit 0
    // the base state is all ones
    logic [`PRBS_ORDER-1:0] serial_next = '1;
    logic                   tx_live = 1'b0;

    prbs_bist_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .checker_mode (checker_mode),
        .rx_bits      (rx_bits),
        .tx_bits      (tx_bits),
        .correct_bits (correct_bits),
        .total_bits   (total_bits),
        .rx_shift     (rx_shift)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string what);
        value_errors++;
        $display("Fail at %0t: %s", $time, what);
    endtask

    function automatic int random_delay();
        return 1 + int'($unsigned($random(seed)) % 47);
    endfunction

    // channel model, serial delay of delay bits plus at most one flipped bit per word
    always @(posedge clk) begin
        logic [4*`PRBS_LANES-1:0] stream;
        prbs_pkg::lane_word_t     flip;
        int                       lane_pick;
        stream = {tx_bits, tx_hist};
        flip = '0;
        if (inject_on && ($unsigned($random(seed)) % 3 == 0)) begin
            lane_pick = int'($unsigned($random(seed)) % `PRBS_LANES);
            flip[lane_pick] = 1'b1;
            flips_injected <= flips_injected + 1;
        end
        tx_hist <= stream[4*`PRBS_LANES-1:`PRBS_LANES];
        rx_bits <= stream[3*`PRBS_LANES-delay +: `PRBS_LANES] ^ flip;
    end

    // serial model of the transmit stream
    // each new bit is the XOR of the bits 7 and 6 places back
    always @(posedge clk) begin
        prbs_pkg::lane_word_t   expect_word;
        logic [`PRBS_ORDER-1:0] upcoming;
        upcoming = serial_next;
        for (int lane = 0; lane < `PRBS_LANES; lane++) begin
            expect_word[lane] = upcoming[0];
            upcoming = {upcoming[0] ^ upcoming[1], upcoming[`PRBS_ORDER-1:1]};
        end
        if (tx_live) begin
            assert (tx_bits == expect_word)
                else report_mismatch($sformatf("tx_bits %h, expected %h",
                                               tx_bits, expect_word));
            serial_next <= upcoming;
        end
        tx_live <= !rst;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run exceeded the cycle limit of %0d cycles, %0d value errors",
                     cycle_limit, value_errors);
            $display("Something failed");
            $finish;
        end
    end

    // reset mode and rst clear the counters and park the window at all ones
    assert property (@(posedge clk)
        (cycle_count > 2 && ($past(rst) || $past(checker_mode) == prbs_pkg::mode_reset))
            |-> (correct_bits == '0 && total_bits == '0 && rx_shift == '1))
        else report_mismatch($sformatf("after reset correct %0d total %0d rx_shift %0d",
                                       correct_bits, total_bits, rx_shift));

    // slips only move down by one, 0 wraps to all ones in 4 bits
    assert property (@(posedge clk)
        (cycle_count > 2 && !$past(rst) && $past(checker_mode) == prbs_pkg::mode_align)
            |-> (rx_shift == $past(rx_shift) || rx_shift == $past(rx_shift) - 4'd1))
        else report_mismatch($sformatf("rx_shift jumped to %0d while aligning", rx_shift));

    assert property (@(posedge clk)
        (cycle_count > 2 && !$past(rst) && $past(checker_mode) == prbs_pkg::mode_test)
            |-> (total_bits == $past(total_bits) + prbs_pkg::bit_count_t'(`PRBS_LANES)))
        else report_mismatch($sformatf("total_bits %0d did not step by 16", total_bits));

    assert property (@(posedge clk)
        (clean_check && total_bits != '0) |-> (correct_bits == total_bits))
        else report_mismatch($sformatf("clean stream counted %0d of %0d bits correct",
                                       correct_bits, total_bits));

    assert property (@(posedge clk)
        (cycle_count > 2 && !$past(rst) && $past(checker_mode) == prbs_pkg::mode_freeze)
            |-> ($stable(correct_bits) && $stable(total_bits) && $stable(rx_shift)))
        else report_mismatch("counters or rx_shift moved in freeze mode");

    task automatic clear_and_check();
        checker_mode <= prbs_pkg::mode_reset;
        repeat (3) @(posedge clk);
        assert (correct_bits == '0 && total_bits == '0)
            else report_mismatch($sformatf("reset mode left counters at %0d and %0d",
                                           correct_bits, total_bits));
        assert (rx_shift == '1)
            else report_mismatch($sformatf("reset mode left rx_shift at %0d", rx_shift));
    endtask

    // a search slips every few cycles, so a long quiet stretch means locked
    task automatic align_and_wait();
        logic [`PRBS_SHIFT_W-1:0] last_shift;
        int                       stable;
        checker_mode <= prbs_pkg::mode_align;
        last_shift = rx_shift;
        stable = 0;
        while (stable < stable_cycles) begin
            @(posedge clk);
            if (rx_shift == last_shift) begin
                stable++;
            end else begin
                stable = 0;
                last_shift = rx_shift;
            end
        end
    endtask

    task automatic count_clean();
        checker_mode <= prbs_pkg::mode_test;
        clean_check <= 1'b1;
        repeat (clean_cycles) @(posedge clk);
        // first test edge is seen one cycle after the mode change
        assert (total_bits == prbs_pkg::bit_count_t'(`PRBS_LANES * (clean_cycles - 1)))
            else report_mismatch($sformatf("total_bits %0d after clean run", total_bits));
        assert (correct_bits == total_bits)
            else report_mismatch($sformatf("correct_bits %0d after clean run", correct_bits));
        clean_check <= 1'b0;
    endtask

    task automatic count_errors();
        prbs_pkg::bit_count_t missed_before;
        prbs_pkg::bit_count_t missed;
        int                   flips_before;
        missed_before = total_bits - correct_bits;
        flips_before = flips_injected;
        inject_on <= 1'b1;
        repeat (error_cycles) @(posedge clk);
        inject_on <= 1'b0;
        // let the last flipped word reach the counters
        repeat (drain_cycles) @(posedge clk);
        missed = total_bits - correct_bits - missed_before;
        assert (missed == prbs_pkg::bit_count_t'(flips_injected - flips_before))
            else report_mismatch($sformatf("counted %0d bad bits for %0d flips",
                                           missed, flips_injected - flips_before));
    endtask

    task automatic freeze_with_errors();
        prbs_pkg::bit_count_t     correct_held;
        prbs_pkg::bit_count_t     total_held;
        logic [`PRBS_SHIFT_W-1:0] shift_held;
        checker_mode <= prbs_pkg::mode_freeze;
        inject_on <= 1'b1;
        repeat (2) @(posedge clk);
        correct_held = correct_bits;
        total_held = total_bits;
        shift_held = rx_shift;
        repeat (freeze_cycles) @(posedge clk);
        assert (correct_bits == correct_held && total_bits == total_held
                && rx_shift == shift_held)
            else report_mismatch("freeze mode did not hold its values");
        inject_on <= 1'b0;
    endtask

    initial begin
        int next_delay;
        seed = 32'hd184_701c;
        rst = 1'b1;
        checker_mode = prbs_pkg::mode_reset;
        inject_on = 1'b0;
        clean_check = 1'b0;
        delay = random_delay();
        $display("first run with a channel delay of %0d bits", delay);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        clear_and_check();
        align_and_wait();
        count_clean();
        count_errors();
        freeze_with_errors();

        // second run through a different channel delay
        next_delay = random_delay();
        while (next_delay == delay) begin
            next_delay = random_delay();
        end
        $display("second run with a channel delay of %0d bits", next_delay);
        delay <= next_delay;
        clear_and_check();
        align_and_wait();
        count_clean();

        $display("checks done, %0d value errors, %0d flips injected, %0d cycles",
                 value_errors, flips_injected, cycle_count);
        if (value_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
